/* lv_reg_pkg.sv */
//==============================
// register map, access request and response structs
// mode union, crc-8 helpers
//==============================
package lv_reg_pkg;

    //==============================
    // widths and map
    //==============================
    localparam int REG_AW    = 8;
    localparam int REG_DW    = 8;
    localparam int REG_CRC_W = 8;

    localparam logic [REG_CRC_W-1:0] CRC_POLY = 8'h07;
    localparam logic [REG_CRC_W-1:0] CRC_INIT = 8'hFF;

    localparam logic [REG_AW-1:0] ADDR_MODE      = 8'h00;
    localparam logic [REG_AW-1:0] ADDR_STATUS1   = 8'h01; // sticky errors
    localparam logic [REG_AW-1:0] ADDR_STATUS3   = 8'h02; // live pins
    localparam logic [REG_AW-1:0] ADDR_TRIM_BASE = 8'h10;

    localparam int TRIM_NUM = 8;
    localparam int TRIM_IW  = $clog2(TRIM_NUM);

    //==============================
    // access path types
    //==============================
    typedef struct packed {
        logic                 wr;
        logic                 rd;
        logic [REG_AW-1:0]    addr;
        logic [REG_DW-1:0]    wdata;
        logic [REG_CRC_W-1:0] wcrc;
    } rac_req_t;

    typedef struct packed {
        logic              wen;
        logic              ren;
        logic [REG_AW-1:0] addr;
        logic [REG_DW-1:0] data;
        logic              crc_err;
        logic              addr_err;
    } rac_cmd_t;

    typedef struct packed {
        logic              vld;
        logic              rd;    // 0 on writes and rejected accesses
        logic [REG_AW-1:0] addr;
        logic [REG_DW-1:0] data;
    } rac_rsp_t;

    typedef struct packed {
        logic [2:0] rsvd;
        logic       rtmon;
        logic       adc2_en;
        logic       adc1_en;
        logic       cfg_en;
        logic       normal_en;
    } reg_mode_s;

    typedef union packed {
        logic [REG_DW-1:0] raw;
        reg_mode_s         mode;
    } reg_word_u;

    // msb first, one byte per call
    function automatic logic [REG_CRC_W-1:0] crc8_update(
        input logic [REG_CRC_W-1:0] crc,
        input logic [REG_DW-1:0]    data
    );
        logic [REG_CRC_W-1:0] c;
        c = crc ^ data;
        for (int i = 0; i < REG_DW; i++) begin
            c = c[REG_CRC_W-1] ? ((c << 1) ^ CRC_POLY) : (c << 1);
        end
        return c;
    endfunction

    // address byte first, then data
    function automatic logic [REG_CRC_W-1:0] rac_crc(
        input logic [REG_AW-1:0] addr,
        input logic [REG_DW-1:0] data
    );
        return crc8_update(crc8_update(CRC_INIT, addr), data);
    endfunction

    function automatic logic is_trim_addr(input logic [REG_AW-1:0] addr);
        return (addr >= ADDR_TRIM_BASE) && (addr < ADDR_TRIM_BASE + TRIM_NUM);
    endfunction

endpackage

/* lv_stat_pkg.sv */
//==============================
// status pin and sticky error layouts
//==============================
package lv_stat_pkg;

    localparam int STAT_PIN_NUM = 6;
    localparam int ERR_PIN_NUM  = 4;  // dterr, mmerr, ov, uv
    localparam int SYNC_STAGES  = 2;

    // reads back as STATUS3[5:0]
    typedef struct packed {
        logic pwma;
        logic pwm;
        logic fsstate;
        logic fsenb_n;
        logic intb;
        logic inta;
    } stat_pins_s;

    // reads back as STATUS1[5:0]
    typedef struct packed {
        logic vsup_uv;    // uv_n pin low
        logic vsup_ov;
        logic pwm_mmerr;
        logic pwm_dterr;
        logic addr_err;
        logic crc_err;
    } err_flags_s;

endpackage

/* lv_status_coll.sv */
//==============================
// pin synchronizers, sticky error flags, intb_n
//==============================
`timescale 1ns/1ps

module lv_status_coll import lv_stat_pkg::*; (
    input  logic       i_clk,
    input  logic       i_arst_n,
    input  stat_pins_s i_pins,
    input  logic       i_pwm_dterr,
    input  logic       i_pwm_mmerr,
    input  logic       i_vsup_ov,
    input  logic       i_vsup_uv_n,
    input  logic       i_crc_err_evt,
    input  logic       i_addr_err_evt,
    input  err_flags_s i_clr_mask,
    output stat_pins_s o_pins,
    output err_flags_s o_flags,
    output logic       o_intb_n
);

    logic [SYNC_STAGES-1:0][STAT_PIN_NUM+ERR_PIN_NUM-1:0] sync_q;
    logic [STAT_PIN_NUM+ERR_PIN_NUM-1:0]                  sync_in;
    logic [STAT_PIN_NUM+ERR_PIN_NUM-1:0]                  sync_out;
    logic [ERR_PIN_NUM-1:0]                               err_pin;
    err_flags_s                                           flag_set;

    // uv is carried active high so the chain can reset to 0
    assign sync_in = {~i_vsup_uv_n, i_vsup_ov, i_pwm_mmerr, i_pwm_dterr, i_pins};

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], sync_in};
        end
    end

    assign sync_out = sync_q[SYNC_STAGES-1];
    assign o_pins   = sync_out[STAT_PIN_NUM-1:0];
    assign err_pin  = sync_out[STAT_PIN_NUM +: ERR_PIN_NUM];

    always_comb begin
        flag_set           = '0;
        flag_set.crc_err   = i_crc_err_evt;
        flag_set.addr_err  = i_addr_err_evt;
        flag_set.pwm_dterr = err_pin[0];
        flag_set.pwm_mmerr = err_pin[1];
        flag_set.vsup_ov   = err_pin[2];
        flag_set.vsup_uv   = err_pin[3];
    end

    // set wins over clear
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_flags <= '0;
        end else begin
            o_flags <= (o_flags & ~i_clr_mask) | flag_set;
        end
    end

    assign o_intb_n = ~|o_flags;

endmodule

/* lv_rac_chk.sv */
//==============================
// stage 1, crc and address check
//==============================
`timescale 1ns/1ps

module lv_rac_chk import lv_reg_pkg::*; (
    input  logic     i_clk,
    input  logic     i_arst_n,
    input  rac_req_t i_req,
    output rac_cmd_t o_cmd
);

    logic [REG_CRC_W-1:0] crc_exp;
    logic                 addr_hit;
    logic                 crc_bad;
    logic                 addr_bad;

    assign crc_exp = rac_crc(i_req.addr, i_req.wdata);

    always_comb begin
        addr_hit = 1'b0;
        case (i_req.addr)
            ADDR_MODE,
            ADDR_STATUS1,
            ADDR_STATUS3: addr_hit = 1'b1;
            default:      addr_hit = is_trim_addr(i_req.addr);
        endcase
    end

    assign crc_bad  = i_req.wr && (crc_exp != i_req.wcrc);
    assign addr_bad = (i_req.wr || i_req.rd) && !addr_hit;

    //==============================
    // command register
    //==============================
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_cmd <= '0;
        end else begin
            o_cmd.wen      <= i_req.wr & ~crc_bad & ~addr_bad;
            o_cmd.ren      <= i_req.rd & ~addr_bad;
            o_cmd.addr     <= i_req.addr;
            o_cmd.data     <= i_req.wdata;
            o_cmd.crc_err  <= crc_bad;
            o_cmd.addr_err <= addr_bad;
        end
    end

    // read and write strobes from the host are exclusive
    a_one_strobe: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(i_req.wr && i_req.rd));

endmodule

/* lv_reg_bank.sv */
//==============================
// stage 2, mode and trim registers, status read mux
//==============================
`timescale 1ns/1ps

module lv_reg_bank import lv_reg_pkg::*; import lv_stat_pkg::*; (
    input  logic                             i_clk,
    input  logic                             i_arst_n,
    input  rac_cmd_t                         i_cmd,
    input  err_flags_s                       i_flags,
    input  stat_pins_s                       i_pins,
    output rac_rsp_t                         o_rsp,
    output logic                             o_crc_err_evt,
    output logic                             o_addr_err_evt,
    output err_flags_s                       o_clr_mask,
    output reg_mode_s                        o_mode,
    output logic [TRIM_NUM-1:0][REG_DW-1:0]  o_trim
);

    reg_word_u                         mode_q;
    logic [TRIM_NUM-1:0][REG_DW-1:0]   trim_q;
    logic [TRIM_IW-1:0]                trim_idx;
    logic                              trim_hit;
    logic                              wr_mode;
    logic                              wr_trim;
    logic                              wr_stat1;
    logic                              cmd_vld;
    logic [REG_DW-1:0]                 rdata;

    assign trim_hit = is_trim_addr(i_cmd.addr);
    assign trim_idx = TRIM_IW'(i_cmd.addr - ADDR_TRIM_BASE);
    assign cmd_vld  = i_cmd.wen | i_cmd.ren | i_cmd.crc_err | i_cmd.addr_err;

    //==============================
    // write decode
    //==============================
    assign wr_mode  = i_cmd.wen && (i_cmd.addr == ADDR_MODE);
    assign wr_trim  = i_cmd.wen && trim_hit && mode_q.mode.cfg_en; // trim locked w/o cfg_en
    assign wr_stat1 = i_cmd.wen && (i_cmd.addr == ADDR_STATUS1);

    // write-one-to-clear mask for the collector
    assign o_clr_mask     = wr_stat1 ? i_cmd.data[$bits(err_flags_s)-1:0] : '0;
    assign o_crc_err_evt  = i_cmd.crc_err;
    assign o_addr_err_evt = i_cmd.addr_err;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            mode_q <= '0;
            trim_q <= '0;
        end else begin
            if (wr_mode) begin
                mode_q.raw <= i_cmd.data;
            end
            if (wr_trim) begin
                trim_q[trim_idx] <= i_cmd.data;
            end
        end
    end

    assign o_mode = mode_q.mode;
    assign o_trim = trim_q;

    //==============================
    // read mux
    //==============================
    always_comb begin
        case (i_cmd.addr)
            ADDR_MODE:    rdata = mode_q.raw;
            ADDR_STATUS1: rdata = REG_DW'(i_flags);
            ADDR_STATUS3: rdata = REG_DW'(i_pins);
            default:      rdata = trim_hit ? trim_q[trim_idx] : '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_rsp <= '0;
        end else begin
            o_rsp.vld  <= cmd_vld;
            o_rsp.rd   <= i_cmd.ren;
            o_rsp.addr <= i_cmd.addr;
            o_rsp.data <= i_cmd.ren ? rdata : '0;
        end
    end

    a_trim_locked: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !mode_q.mode.cfg_en |=> $stable(trim_q));

endmodule

/* lv_rsp_gen.sv */
//==============================
// stage 3, read crc and acknowledge
//==============================
`timescale 1ns/1ps

module lv_rsp_gen import lv_reg_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_arst_n,
    input  rac_rsp_t             i_rsp,
    output logic                 o_ack,
    output logic [REG_DW-1:0]    o_rsp_data,
    output logic [REG_CRC_W-1:0] o_rsp_crc
);

    logic [REG_CRC_W-1:0] rd_crc;

    // same fold as the write crc over addr and read data
    assign rd_crc = rac_crc(i_rsp.addr, i_rsp.data);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ack      <= 1'b0;
            o_rsp_data <= '0;
            o_rsp_crc  <= '0;
        end else begin
            o_ack      <= i_rsp.vld;
            o_rsp_data <= i_rsp.rd ? i_rsp.data : '0; // writes answer with zeros
            o_rsp_crc  <= i_rsp.rd ? rd_crc : '0;
        end
    end

endmodule

/* lv_core.sv */
//==============================
// register access pipeline and status collector
//==============================
`timescale 1ns/1ps

module lv_core import lv_reg_pkg::*; import lv_stat_pkg::*; (
    input  logic                            i_clk,
    input  logic                            i_arst_n,
    input  rac_req_t                        i_req,
    input  stat_pins_s                      i_pins,
    input  logic                            i_pwm_dterr,
    input  logic                            i_pwm_mmerr,
    input  logic                            i_vsup_ov,
    input  logic                            i_vsup_uv_n,
    output logic                            o_ack,
    output logic [REG_DW-1:0]               o_rsp_data,
    output logic [REG_CRC_W-1:0]            o_rsp_crc,
    output logic                            o_adc1_en,
    output logic                            o_adc2_en,
    output logic                            o_rtmon,
    output logic [TRIM_NUM-1:0][REG_DW-1:0] o_trim,
    output logic                            o_intb_n
);

    rac_cmd_t   cmd;
    rac_rsp_t   rsp;
    reg_mode_s  mode;
    err_flags_s flags;
    err_flags_s clr_mask;
    stat_pins_s pins_sync;
    logic       crc_err_evt;
    logic       addr_err_evt;

    lv_rac_chk u_rac_chk (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_req    (i_req),
        .o_cmd    (cmd)
    );

    lv_reg_bank u_reg_bank (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_cmd          (cmd),
        .i_flags        (flags),
        .i_pins         (pins_sync),
        .o_rsp          (rsp),
        .o_crc_err_evt  (crc_err_evt),
        .o_addr_err_evt (addr_err_evt),
        .o_clr_mask     (clr_mask),
        .o_mode         (mode),
        .o_trim         (o_trim)
    );

    lv_rsp_gen u_rsp_gen (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_rsp      (rsp),
        .o_ack      (o_ack),
        .o_rsp_data (o_rsp_data),
        .o_rsp_crc  (o_rsp_crc)
    );

    lv_status_coll u_status_coll (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_pins         (i_pins),
        .i_pwm_dterr    (i_pwm_dterr),
        .i_pwm_mmerr    (i_pwm_mmerr),
        .i_vsup_ov      (i_vsup_ov),
        .i_vsup_uv_n    (i_vsup_uv_n),
        .i_crc_err_evt  (crc_err_evt),
        .i_addr_err_evt (addr_err_evt),
        .i_clr_mask     (clr_mask),
        .o_pins         (pins_sync),
        .o_flags        (flags),
        .o_intb_n       (o_intb_n)
    );

    // mode fields to the analog side
    assign o_adc1_en = mode.adc1_en;
    assign o_adc2_en = mode.adc2_en;
    assign o_rtmon   = mode.rtmon;

endmodule

/* tb_lv_core.sv */
//==============================
// testbench for lv_core, random register traffic
// against a reference model of registers and flags
//==============================
`timescale 1ns/1ps

module tb_lv_core
    import lv_reg_pkg::*;
    import lv_stat_pkg::*;
();

    localparam int MODE_ROUNDS = 8;
    localparam int TRIM_ROUNDS = 24;
    localparam int ERR_ROUNDS  = 12;
    localparam int PIN_VECTORS = 16;
    localparam int STIM_CYCLES = 3 + MODE_ROUNDS * 7 + TRIM_ROUNDS * 3 + 4
                               + ERR_ROUNDS * 2 + 12 + PIN_VECTORS * 5 + 14;
    localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 100;

    typedef struct packed {
        logic                 ack;
        logic [REG_DW-1:0]    data;
        logic [REG_CRC_W-1:0] crc;
    } exp_t;

    logic                            clk = 1'b0;
    logic                            arst_n;
    rac_req_t                        i_req;
    stat_pins_s                      i_pins;
    logic                            i_pwm_dterr;
    logic                            i_pwm_mmerr;
    logic                            i_vsup_ov;
    logic                            i_vsup_uv_n;
    logic                            o_ack;
    logic [REG_DW-1:0]               o_rsp_data;
    logic [REG_CRC_W-1:0]            o_rsp_crc;
    logic                            o_adc1_en;
    logic                            o_adc2_en;
    logic                            o_rtmon;
    logic [TRIM_NUM-1:0][REG_DW-1:0] o_trim;
    logic                            o_intb_n;

    // reference model state
    logic [7:0]  m_mode;
    logic [7:0]  m_trim [TRIM_NUM];
    logic [5:0]  m_flags;
    logic [5:0]  m_pin_err;   // flag positions of active pin errors
    logic [5:0]  m_pins;
    exp_t        exp_q [$];

    logic [31:0] lcg_state = 32'd90149;
    int          n_checks = 0;
    int          n_errors = 0;
    int          chk_mark = 0;
    int          err_mark = 0;
    int          cycles = 0;

    lv_core dut (
        .i_clk       (clk),
        .i_arst_n    (arst_n),
        .i_req       (i_req),
        .i_pins      (i_pins),
        .i_pwm_dterr (i_pwm_dterr),
        .i_pwm_mmerr (i_pwm_mmerr),
        .i_vsup_ov   (i_vsup_ov),
        .i_vsup_uv_n (i_vsup_uv_n),
        .o_ack       (o_ack),
        .o_rsp_data  (o_rsp_data),
        .o_rsp_crc   (o_rsp_crc),
        .o_adc1_en   (o_adc1_en),
        .o_adc2_en   (o_adc2_en),
        .o_rtmon     (o_rtmon),
        .o_trim      (o_trim),
        .o_intb_n    (o_intb_n)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [7:0] rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:24];
    endfunction

    // bit serial crc-8 over address then data
    function automatic logic [7:0] ref_crc(input logic [7:0] addr, input logic [7:0] data);
        logic [7:0]  crc;
        logic [15:0] stream;
        logic        fb;
        crc    = CRC_INIT;
        stream = {addr, data};
        for (int i = 15; i >= 0; i--) begin
            fb  = crc[7] ^ stream[i];
            crc = {crc[6:0], 1'b0} ^ (fb ? CRC_POLY : 8'h00);
        end
        return crc;
    endfunction

    function automatic logic addr_mapped(input logic [7:0] addr);
        return (addr <= 8'h02) || (addr >= 8'h10 && addr <= 8'h17);
    endfunction

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    //==============================
    // one clock of traffic
    //==============================
    task automatic issue_cycle(input rac_req_t req, input exp_t e);
        exp_t old;
        @(negedge clk);
        if (exp_q.size() == 3) begin   // issued three cycles ago
            old = exp_q.pop_front();
            compare(o_ack, old.ack, "ack");
            compare(o_rsp_data, old.data, "rsp_data");
            compare(o_rsp_crc, old.crc, "rsp_crc");
        end
        i_req = req;
        exp_q.push_back(e);
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            issue_cycle('0, '0);
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data, input logic corrupt);
        rac_req_t req;
        exp_t     e;
        req       = '0;
        req.wr    = 1'b1;
        req.addr  = addr;
        req.wdata = data;
        req.wcrc  = ref_crc(addr, data) ^ (corrupt ? (rand_byte() | 8'h01) : 8'h00);
        if (corrupt) m_flags[0] = 1'b1;
        if (!addr_mapped(addr)) m_flags[1] = 1'b1;
        if (addr_mapped(addr) && !corrupt) begin
            if (addr == ADDR_MODE) begin
                m_mode = data;
            end else if (addr >= ADDR_TRIM_BASE) begin
                if (m_mode[1]) m_trim[addr - ADDR_TRIM_BASE] = data;  // cfg_en
            end else if (addr == ADDR_STATUS1) begin
                m_flags = (m_flags & ~data[5:0]) | m_pin_err;
            end
        end
        e     = '0;
        e.ack = 1'b1;
        issue_cycle(req, e);
    endtask

    task automatic read_reg(input logic [7:0] addr);
        rac_req_t req;
        exp_t     e;
        req      = '0;
        req.rd   = 1'b1;
        req.addr = addr;
        e        = '0;
        e.ack    = 1'b1;
        if (!addr_mapped(addr)) begin
            m_flags[1] = 1'b1;
        end else begin
            if (addr == ADDR_MODE) e.data = m_mode;
            else if (addr == ADDR_STATUS1) e.data = {2'b00, m_flags};
            else if (addr == ADDR_STATUS3) e.data = {2'b00, m_pins};
            else e.data = m_trim[addr - ADDR_TRIM_BASE];
            e.crc = ref_crc(addr, e.data);
        end
        issue_cycle(req, e);
    endtask

    task automatic apply_pins(input logic [7:0] pins, input logic [7:0] err);
        i_pins      = pins[5:0];
        i_pwm_dterr = err[0];
        i_pwm_mmerr = err[1];
        i_vsup_ov   = err[2];
        i_vsup_uv_n = ~err[3];
        m_pins      = pins[5:0];
        m_pin_err   = {err[3:0], 2'b00};
        m_flags     = m_flags | m_pin_err;
    endtask

    task automatic check_outputs();
        compare(o_adc1_en, m_mode[2], "adc1_en");
        compare(o_adc2_en, m_mode[3], "adc2_en");
        compare(o_rtmon, m_mode[4], "rtmon");
        compare(o_intb_n, m_flags == 6'd0, "intb_n");
        for (int i = 0; i < TRIM_NUM; i++) begin
            compare(o_trim[i], m_trim[i], "o_trim");
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-12s %0d checks, %0d errors", name, n_checks - chk_mark,
                 n_errors - err_mark);
        chk_mark = n_checks;
        err_mark = n_errors;
    endtask

    //==============================
    // test sequence
    //==============================
    initial begin
        logic [7:0] r;
        logic [7:0] d;
        logic [7:0] a;
        i_req       = '0;
        i_pins      = '0;
        i_pwm_dterr = 1'b0;
        i_pwm_mmerr = 1'b0;
        i_vsup_ov   = 1'b0;
        i_vsup_uv_n = 1'b1;
        arst_n      = 1'b0;
        m_mode      = '0;
        m_trim      = '{default: '0};
        m_flags     = '0;
        m_pin_err   = '0;
        m_pins      = '0;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;

        compare(o_ack, 1'b0, "ack after reset");
        check_outputs();
        end_test("reset");

        for (int i = 0; i < MODE_ROUNDS; i++) begin
            write_reg(ADDR_MODE, rand_byte(), 1'b0);
            write_reg(ADDR_MODE, rand_byte(), 1'b0);
            read_reg(ADDR_MODE);
            idle_cycles(4);
            check_outputs();
        end
        end_test("mode");

        for (int i = 0; i < TRIM_ROUNDS; i++) begin
            r    = rand_byte();
            d    = rand_byte();
            d[1] = r[0];   // cfg_en
            a    = ADDR_TRIM_BASE + {5'b0, r[3:1]};
            write_reg(ADDR_MODE, d, 1'b0);
            write_reg(a, rand_byte(), 1'b0);
            read_reg(a);
        end
        idle_cycles(4);
        check_outputs();
        end_test("trim_gate");

        write_reg(ADDR_STATUS1, 8'hFF, 1'b0);
        for (int i = 0; i < ERR_ROUNDS; i++) begin
            r = rand_byte();
            a = rand_byte();
            if (addr_mapped(a)) a = a + 8'h40;
            case (r[1:0])
                2'd0:    write_reg(ADDR_MODE, rand_byte(), 1'b1);
                2'd1:    write_reg(ADDR_TRIM_BASE + {5'b0, r[4:2]}, rand_byte(), 1'b1);
                2'd2:    write_reg(a, rand_byte(), 1'b0);
                default: read_reg(a);
            endcase
            read_reg(r[5] ? ADDR_MODE : ADDR_TRIM_BASE + {5'b0, r[4:2]});
        end
        read_reg(ADDR_STATUS1);
        idle_cycles(4);
        check_outputs();
        write_reg(ADDR_STATUS1, 8'hFF, 1'b0);
        read_reg(ADDR_STATUS1);
        idle_cycles(4);
        check_outputs();
        end_test("errors");

        for (int i = 0; i < PIN_VECTORS; i++) begin
            read_reg(ADDR_STATUS1);
            r = rand_byte();
            apply_pins(r, rand_byte() & rand_byte());
            idle_cycles(2);
            read_reg(ADDR_STATUS3);
            if (r[7]) write_reg(ADDR_STATUS1, 8'hFF, 1'b0);
            else read_reg(ADDR_STATUS1);
        end
        idle_cycles(1);
        apply_pins(rand_byte(), 8'h00);   // errors released
        idle_cycles(2);
        write_reg(ADDR_STATUS1, 8'hFF, 1'b0);
        read_reg(ADDR_STATUS1);
        idle_cycles(4);
        check_outputs();
        end_test("pins_flags");

        $display("total: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* sim.f */
lv_reg_pkg.sv
lv_stat_pkg.sv
lv_status_coll.sv
lv_rac_chk.sv
lv_reg_bank.sv
lv_rsp_gen.sv
lv_core.sv
tb_lv_core.sv

/* run.sh */
#!/bin/sh
# build and run the lv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_lv_core -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Test failures found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"
